// File: src/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // hypervector geometry
    localparam int hv_dim       = 1024;
    localparam int word_w       = 32;
    localparam int words_per_hv = hv_dim / word_w;
    localparam int word_idx_w   = $clog2(words_per_hv);

    // item memory
    localparam int item_depth  = 64;
    localparam int item_addr_w = $clog2(item_depth);

    // instruction format: opcode in the top bits, operand in the low bits
    localparam int inst_w    = 16;
    localparam int opcode_w  = 4;
    localparam int operand_w = 10;

    // xorshift start state
    localparam logic [word_w-1:0] rng_seed = 32'h2463534d;

    typedef logic [hv_dim-1:0]      hv_t;
    typedef logic [item_addr_w-1:0] item_addr_t;

    // unlisted encodings fall through to nop in the executor
    typedef enum logic [opcode_w-1:0] {
        op_nop       = 4'h0,
        op_load      = 4'h1,
        op_bind      = 4'h2,
        op_move      = 4'h3,
        op_permute   = 4'h4,
        op_store     = 4'h5,
        op_writeback = 4'h6
    } opcode_t;

endpackage

`default_nettype wire

// File: src/hv_mem_if.sv
`default_nettype none

// one write requester of item memory
interface hv_mem_if import hdc_pkg::*; ();

    logic       wr_req;
    item_addr_t wr_addr;
    hv_t        wr_data;
    logic       wr_grant;

    // address and data stay put until the grant arrives
    modport requester (
        output wr_req,
        output wr_addr,
        output wr_data,
        input  wr_grant
    );

    modport arbiter (
        input  wr_req,
        input  wr_addr,
        input  wr_data,
        output wr_grant
    );

endinterface

`default_nettype wire

// File: src/xorshift_rng.sv
`default_nettype none

module xorshift_rng import hdc_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              step,
    input  wire              reseed,
    output logic [word_w-1:0] rand_word
);

    logic [word_w-1:0] state;
    logic [word_w-1:0] mix_1;
    logic [word_w-1:0] mix_2;
    logic [word_w-1:0] next_state;

    // xorshift32 with shifts 13, 17, 5
    always_comb begin
        mix_1      = state ^ (state << 13);
        mix_2      = mix_1 ^ (mix_1 >> 17);
        next_state = mix_2 ^ (mix_2 << 5);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rng_seed;
        end else if (reseed) begin
            state <= rng_seed;
        end else if (step) begin
            state <= next_state;
        end
    end

    assign rand_word = state;

endmodule

`default_nettype wire

// File: src/hv_generator.sv
`default_nettype none

module hv_generator import hdc_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               gen,
    input  wire               reset_item,
    input  wire item_addr_t   item_count,
    input  wire [word_w-1:0]  rand_word,
    output logic              step,
    output logic              reseed,
    output logic              finish_gen,
    hv_mem_if.requester       wr
);

    logic [word_idx_w-1:0] word_cnt;
    item_addr_t            addr_cnt;
    logic                  pending;
    logic                  done;
    logic                  primed;
    hv_t                   assembly;
    logic                  active;
    logic                  capture;
    logic                  granted;
    logic                  last_word;

    // rng and word counter freeze while a write waits or after the last item
    assign active    = gen && !pending && !done;
    // the seed itself is never captured, the first step only primes the rng
    assign capture   = active && primed;
    assign granted   = pending && wr.wr_grant;
    assign last_word = (word_cnt == word_idx_w'(words_per_hv - 1));

    assign step       = active;
    assign reseed     = !gen && reset_item;
    assign finish_gen = granted && (addr_cnt == item_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            addr_cnt <= '0;
            pending  <= 1'b0;
            done     <= 1'b0;
            primed   <= 1'b0;
        end else if (!gen) begin
            word_cnt <= '0;
            addr_cnt <= '0;
            pending  <= 1'b0;
            done     <= 1'b0;
            // without a reseed the sequence carries on into the next run
            if (reset_item) begin
                primed <= 1'b0;
            end
        end else begin
            if (active) begin
                primed <= 1'b1;
            end
            if (capture) begin
                word_cnt <= word_cnt + 1'b1;
                if (last_word) begin
                    pending <= 1'b1;
                end
            end
            if (granted) begin
                pending  <= 1'b0;
                addr_cnt <= addr_cnt + 1'b1;
                if (addr_cnt == item_count) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // word j lands in bits 32j+31 .. 32j
    always_ff @(posedge clk) begin
        if (capture) begin
            assembly[word_cnt*word_w +: word_w] <= rand_word;
        end
    end

    assign wr.wr_req  = pending;
    assign wr.wr_addr = addr_cnt;
    assign wr.wr_data = assembly;

endmodule

`default_nettype wire

// File: src/item_memory_arbiter.sv
`default_nettype none

module item_memory_arbiter import hdc_pkg::*; (
    hv_mem_if.arbiter   exe_wr,
    hv_mem_if.arbiter   gen_wr,
    output logic        mem_we,
    output item_addr_t  mem_addr,
    output hv_t         mem_data
);

    logic exe_win;
    logic gen_win;

    // fixed priority, executor write-back always wins
    assign exe_win = exe_wr.wr_req;
    assign gen_win = gen_wr.wr_req && !exe_wr.wr_req;

    assign exe_wr.wr_grant = exe_win;
    assign gen_wr.wr_grant = gen_win;

    assign mem_we = exe_win || gen_win;

    // route the winner onto the single write port
    always_comb begin
        if (exe_win) begin
            mem_addr = exe_wr.wr_addr;
            mem_data = exe_wr.wr_data;
        end else begin
            mem_addr = gen_wr.wr_addr;
            mem_data = gen_wr.wr_data;
        end
    end

endmodule

`default_nettype wire

// File: src/item_memory.sv
`default_nettype none

module item_memory import hdc_pkg::*; (
    input  wire             clk,
    input  wire             mem_we,
    input  wire item_addr_t mem_addr,
    input  wire hv_t        mem_data,
    input  wire item_addr_t rd_addr,
    output hv_t             rd_data
);

    hv_t mem [item_depth];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_data;
        end
    end

    // one cycle read latency, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: src/hv_executor.sv
`default_nettype none

module hv_executor import hdc_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              get_v,
    input  wire [inst_w-1:0] get_d,
    input  wire hv_t         rd_data,
    output item_addr_t       rd_addr,
    output logic             store,
    output hv_t              core_result,
    hv_mem_if.requester      wr
);

    logic                 inst_v;
    opcode_t              inst_op;
    logic [operand_w-1:0] inst_operand;
    hv_t                  reg_a;
    hv_t                  reg_b;
    logic                 wb_req;
    item_addr_t           wb_addr;
    logic                 do_store;
    logic                 do_wb;

    // rotate left, amount taken modulo hv_dim
    function automatic hv_t rotl(input hv_t v, input logic [operand_w-1:0] amt);
        logic [2*hv_dim-1:0] wide;
        wide = {v, v} << amt;
        return wide[2*hv_dim-1 -: hv_dim];
    endfunction

    // load address goes out in the strobe cycle so data is back in time
    assign rd_addr = item_addr_t'(get_d[item_addr_w-1:0]);

    assign do_store = inst_v && (inst_op == op_store);
    assign do_wb    = inst_v && (inst_op == op_writeback);

    // decode stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_v  <= 1'b0;
            inst_op <= op_nop;
        end else begin
            inst_v <= get_v;
            if (get_v) begin
                inst_op <= opcode_t'(get_d[inst_w-1 -: opcode_w]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (get_v) begin
            inst_operand <= get_d[operand_w-1:0];
        end
    end

    // execute stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a  <= '0;
            reg_b  <= '0;
            store  <= 1'b0;
            wb_req <= 1'b0;
        end else begin
            store  <= do_store;
            // highest priority on the write port, so this is one cycle long
            wb_req <= do_wb || (wb_req && !wr.wr_grant);
            if (inst_v) begin
                case (inst_op)
                    op_load:    reg_b <= rd_data;
                    op_bind:    reg_b <= reg_a ^ reg_b;
                    op_move:    reg_a <= reg_b;
                    op_permute: reg_b <= rotl(reg_b, inst_operand);
                    default:    ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wb) begin
            wb_addr <= item_addr_t'(inst_operand[item_addr_w-1:0]);
        end
    end

    // b cannot change before the next edge, so it is the stored value
    assign core_result = store ? reg_b : '0;

    assign wr.wr_req  = wb_req;
    assign wr.wr_addr = wb_addr;
    assign wr.wr_data = reg_b;

endmodule

`default_nettype wire

// File: src/hdc_core.sv
`default_nettype none

module hdc_core import hdc_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              gen,
    input  wire              reset_item,
    input  wire item_addr_t  item_count,
    input  wire              get_v,
    input  wire [inst_w-1:0] get_d,
    output logic             finish_gen,
    output logic             store,
    output hv_t              core_result
);

    logic [word_w-1:0] rand_word;
    logic              rng_step;
    logic              rng_reseed;
    logic              mem_we;
    item_addr_t        mem_addr;
    hv_t               mem_data;
    item_addr_t        rd_addr;
    hv_t               rd_data;

    hv_mem_if gen_wr ();
    hv_mem_if exe_wr ();

    xorshift_rng u_rng (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (rng_step),
        .reseed    (rng_reseed),
        .rand_word (rand_word)
    );

    hv_generator u_generator (
        .clk        (clk),
        .rst_n      (rst_n),
        .gen        (gen),
        .reset_item (reset_item),
        .item_count (item_count),
        .rand_word  (rand_word),
        .step       (rng_step),
        .reseed     (rng_reseed),
        .finish_gen (finish_gen),
        .wr         (gen_wr.requester)
    );

    hv_executor u_executor (
        .clk         (clk),
        .rst_n       (rst_n),
        .get_v       (get_v),
        .get_d       (get_d),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .store       (store),
        .core_result (core_result),
        .wr          (exe_wr.requester)
    );

    item_memory_arbiter u_arbiter (
        .exe_wr   (exe_wr.arbiter),
        .gen_wr   (gen_wr.arbiter),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_data (mem_data)
    );

    item_memory u_item_memory (
        .clk      (clk),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// File: include/hdc_ref_model.svh
`ifndef HDC_REF_MODEL_SVH
`define HDC_REF_MODEL_SVH

// expected-value model for the testbench
//
// the generator consumes one contiguous xorshift stream. after a reseed
// the first word used is one step past the seed, and each vector takes the
// next 32 words. lowering gen without reset_item keeps the stream going,
// so the next run starts with the word after the last one used

// one xorshift32 step
function automatic logic [hdc_pkg::word_w-1:0] xorshift_step(
    input logic [hdc_pkg::word_w-1:0] s
);
    logic [hdc_pkg::word_w-1:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// next vector of the stream with state advanced past its last word
function automatic hdc_pkg::hv_t next_item_hv(
    inout logic [hdc_pkg::word_w-1:0] state
);
    hdc_pkg::hv_t v;
    v = '0;
    for (int j = 0; j < hdc_pkg::words_per_hv; j++) begin
        state = xorshift_step(state);
        v[j*hdc_pkg::word_w +: hdc_pkg::word_w] = state;
    end
    return v;
endfunction

// permute as a left rotation by amt modulo hv_dim
function automatic hdc_pkg::hv_t rotate_hv_left(
    input hdc_pkg::hv_t v,
    input int unsigned  amt
);
    hdc_pkg::hv_t r;
    int unsigned  k;
    k = amt % hdc_pkg::hv_dim;
    for (int i = 0; i < hdc_pkg::hv_dim; i++) begin
        r[(i + k) % hdc_pkg::hv_dim] = v[i];
    end
    return r;
endfunction

`endif

// File: verif/hdc_core_tb.sv
`default_nettype none

module hdc_core_tb import hdc_pkg::*; ();

    `include "hdc_ref_model.svh"

    logic              clk;
    logic              rst_n;
    logic              gen;
    logic              reset_item;
    item_addr_t        item_count;
    logic              get_v;
    logic [inst_w-1:0] get_d;
    logic              finish_gen;
    logic              store;
    hv_t               core_result;

    hv_t               exp_items [item_depth];
    hv_t               exp_b;
    logic [word_w-1:0] ref_state;

    hdc_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .gen         (gen),
        .reset_item  (reset_item),
        .item_count  (item_count),
        .get_v       (get_v),
        .get_d       (get_d),
        .finish_gen  (finish_gen),
        .store       (store),
        .core_result (core_result)
    );

    always #20 clk = ~clk;

    task automatic check_hv(input string name, input hv_t expected, input hv_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "hypervector mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "bit mismatch in %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // one-cycle strobe that returns 2 units after the sampling edge
    task automatic issue(input opcode_t op, input int unsigned operand);
        get_d = '0;
        get_d[inst_w-1 -: opcode_w] = op;
        get_d[operand_w-1:0] = operand[operand_w-1:0];
        get_v = 1'b1;
        next_cycle();
        get_v = 1'b0;
        get_d = '0;
    endtask

    // store pulse is due exactly two edges after the strobe cycle starts
    task automatic store_check(input string name, input hv_t expected);
        issue(op_store, 0);
        @(posedge clk);
        #1;
        check_bit({name, " store high"}, 1'b1, store);
        check_hv(name, expected, core_result);
        @(posedge clk);
        #1;
        check_bit({name, " store low"}, 1'b0, store);
        check_hv({name, " result cleared"}, '0, core_result);
        #1;
    endtask

    task automatic wait_finish(input string name, input int limit);
        int cycles;
        int pulses;
        cycles = 0;
        pulses = 0;
        while (pulses == 0) begin
            if (cycles == limit) begin
                $display("%s: finish_gen did not pulse within %0d cycles", name, limit);
                $display("Test FAILED");
                $fatal(1, "generator timeout");
            end
            @(posedge clk);
            #1;
            cycles++;
            if (finish_gen) begin
                pulses++;
            end
        end
        // no further pulse once the generator is done
        repeat (40) begin
            @(posedge clk);
            #1;
            if (finish_gen) begin
                pulses++;
            end
        end
        #1;
        check_bit({name, " single finish_gen"}, 1'b1, pulses == 1);
    endtask

    task automatic reset_idle();
        repeat (5) begin
            @(posedge clk);
            #1;
            check_bit("reset store", 1'b0, store);
            check_bit("reset finish_gen", 1'b0, finish_gen);
            check_hv("reset core_result", '0, core_result);
        end
        #1;
    endtask

    task automatic generate_and_readback();
        ref_state = rng_seed;
        for (int i = 0; i < 4; i++) begin
            exp_items[i] = next_item_hv(ref_state);
        end
        item_count = 3;
        gen = 1'b1;
        wait_finish("generate", 2000);
        gen = 1'b0;
        next_cycle();
        for (int i = 0; i < 4; i++) begin
            issue(op_load, i);
            store_check($sformatf("item %0d", i), exp_items[i]);
        end
    endtask

    task automatic load_then_store();
        issue(op_load, 2);
        exp_b = exp_items[2];
        store_check("load store", exp_b);
    endtask

    task automatic bind_move_permute();
        int unsigned amt;
        amt = 1 + ($urandom % (hv_dim - 1));
        issue(op_load, 1);
        issue(op_move, 0);
        issue(op_load, 3);
        issue(op_bind, 0);
        exp_b = exp_items[1] ^ exp_items[3];
        store_check("bind", exp_b);
        issue(op_permute, amt);
        exp_b = rotate_hv_left(exp_b, amt);
        store_check($sformatf("permute %0d", amt), exp_b);
    endtask

    task automatic writeback_during_regen();
        item_addr_t wb_addr;
        // keep clear of the addresses being regenerated
        wb_addr = item_addr_t'(8 + ($urandom % (item_depth - 8)));
        reset_item = 1'b1;
        next_cycle();
        reset_item = 1'b0;
        ref_state = rng_seed;
        for (int i = 0; i < 8; i++) begin
            exp_items[i] = next_item_hv(ref_state);
        end
        item_count = 7;
        gen = 1'b1;
        // write-backs hold off the request for item 4 that was never written before
        repeat (160) next_cycle();
        repeat (8) issue(op_writeback, wb_addr);
        wait_finish("regenerate", 4000);
        gen = 1'b0;
        repeat (3) next_cycle();
        issue(op_load, wb_addr);
        store_check($sformatf("reload %0d", wb_addr), exp_b);
        for (int i = 0; i < 8; i++) begin
            issue(op_load, i);
            store_check($sformatf("regen item %0d", i), exp_items[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h1058d79d));
        clk = 1'b0;
        rst_n = 1'b0;
        gen = 1'b0;
        reset_item = 1'b0;
        item_count = '0;
        get_v = 1'b0;
        get_d = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reset_idle();
        generate_and_readback();
        load_then_store();
        bind_move_permute();
        writeback_during_regen();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
src/hdc_pkg.sv
src/hv_mem_if.sv
src/xorshift_rng.sv
src/hv_generator.sv
src/item_memory_arbiter.sv
src/item_memory.sv
src/hv_executor.sv
src/hdc_core.sv
verif/hdc_core_tb.sv
